/* Makefile */
# Verilator build and run of the test memory channel testbench

VERILATOR ?= verilator
TOP       ?= tb_test_dram_channel
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
rtl/test_dram_pkg.sv
rtl/dram_cfg_regs.sv
rtl/dram_cmd_decode.sv
rtl/mem_1r1w_sync_mask_write_byte.sv
rtl/dram_read_delay.sv
rtl/test_dram_channel.sv
verif/tb_clk_gen.sv
verif/tb_test_dram_channel.sv

/* rtl/dram_cfg_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel control and command counters. Counters wrap and are read-only.
// Change the read delay only while no read is in flight.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dram_cfg_regs (
  input  wire logic                                clk_i,
  input  wire logic                                arst_n_i,
  input  wire logic                                cfg_we_i,
  input  wire logic [test_dram_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  wire logic [test_dram_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  input  wire logic                                rd_fire_i,
  input  wire logic                                wr_fire_i,
  input  wire logic                                err_fire_i,
  output logic      [test_dram_pkg::CFG_DATA_W-1:0] cfg_rdata_o,
  output logic                                     enable_o,
  output logic      [test_dram_pkg::DELAY_W-1:0]    rd_delay_o
);

  import test_dram_pkg::*;

  logic                  enable_q;
  logic [DELAY_W-1:0]    delay_q;
  logic [CFG_DATA_W-1:0] rd_cnt_q;
  logic [CFG_DATA_W-1:0] wr_cnt_q;
  logic [CFG_DATA_W-1:0] err_cnt_q;
  logic                  ctrl_we;

  assign ctrl_we = cfg_we_i && (cfg_reg_e'(cfg_addr_i) == CFG_CTRL);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      delay_q  <= '0;
    end else if (ctrl_we) begin
      enable_q <= cfg_wdata_i[CTRL_EN_BIT];
      delay_q  <= cfg_wdata_i[CTRL_DLY_LSB +: DELAY_W];
    end
  end

  // Event counters, wrap at 2**32
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_cnt_q  <= '0;
      wr_cnt_q  <= '0;
      err_cnt_q <= '0;
    end else begin
      if (rd_fire_i) rd_cnt_q <= rd_cnt_q + 1'b1;
      if (wr_fire_i) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (err_fire_i) err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  // Readback straight from the address
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_reg_e'(cfg_addr_i))
      CFG_CTRL: begin
        cfg_rdata_o[CTRL_EN_BIT]              = enable_q;
        cfg_rdata_o[CTRL_DLY_LSB +: DELAY_W]  = delay_q; // Upper bits stay zero
      end
      CFG_RD_CNT:  cfg_rdata_o = rd_cnt_q;
      CFG_WR_CNT:  cfg_rdata_o = wr_cnt_q;
      CFG_ERR_CNT: cfg_rdata_o = err_cnt_q;
      default:     cfg_rdata_o = '0;
    endcase
  end

  assign enable_o   = enable_q;
  assign rd_delay_o = delay_q;

endmodule

`default_nettype wire

/* rtl/dram_cmd_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered command decoder, one command per cycle and no back-pressure.
// Misaligned byte addresses are dropped and only counted as errors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dram_cmd_decode #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic                                 cmd_v_i,
  input  wire logic                                 cmd_we_i,
  input  wire logic [ADDR_W-1:0]                    cmd_addr_i,
  input  wire logic [DATA_W-1:0]                    cmd_wdata_i,
  input  wire logic [DATA_W/8-1:0]                  cmd_mask_i,
  input  wire logic                                 enable_i,
  output logic                                      r_v_o,
  output logic [ADDR_W-$clog2(DATA_W/8)-1:0]        r_addr_o,
  output logic                                      w_v_o,
  output logic [ADDR_W-$clog2(DATA_W/8)-1:0]        w_addr_o,
  output logic [DATA_W-1:0]                         w_data_o,
  output logic [DATA_W/8-1:0]                       w_mask_o,
  output logic                                      rd_fire_o,
  output logic                                      wr_fire_o,
  output logic                                      err_fire_o
);

  localparam int BYTES   = DATA_W / 8;
  localparam int OFF_W   = $clog2(BYTES);
  localparam int WORD_AW = ADDR_W - OFF_W;

  logic               misaligned;
  logic               rd_ok;
  logic               wr_ok;
  logic [WORD_AW-1:0] word_addr;
  logic               r_v_q;
  logic               w_v_q;
  logic               err_q;

  assign misaligned = (cmd_addr_i % BYTES) != 0;
  assign rd_ok      = cmd_v_i && enable_i && !misaligned && !cmd_we_i;
  assign wr_ok      = cmd_v_i && enable_i && !misaligned && cmd_we_i;
  assign word_addr  = WORD_AW'(cmd_addr_i >> OFF_W);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_v_q <= 1'b0;
      w_v_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      r_v_q <= rd_ok;
      w_v_q <= wr_ok;
      err_q <= cmd_v_i && enable_i && misaligned; // Disabled channel counts nothing
    end
  end

  // Payload only loads on an accepted command
  always_ff @(posedge clk_i) begin
    if (rd_ok) r_addr_o <= word_addr;
    if (wr_ok) begin
      w_addr_o <= word_addr;
      w_data_o <= cmd_wdata_i;
      w_mask_o <= cmd_mask_i;
    end
  end

  assign r_v_o      = r_v_q;
  assign w_v_o      = w_v_q;
  assign rd_fire_o  = r_v_q; // Same cycle as the port strobe
  assign wr_fire_o  = w_v_q;
  assign err_fire_o = err_q;

  a_one_port: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(r_v_o && w_v_o))
    else $error("read and write ports strobed together");

endmodule

`default_nettype wire

/* rtl/dram_read_delay.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read response delay of 1 + delay_i cycles; tap 0 skips the extra delay.
// delay_i must stay stable while any stage holds a response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dram_read_delay #(
  parameter int DATA_W = 32
) (
  input  wire logic                             clk_i,
  input  wire logic                             arst_n_i,
  input  wire logic                             v_i,
  input  wire logic [DATA_W-1:0]                data_i,
  input  wire logic [test_dram_pkg::DELAY_W-1:0] delay_i,
  output logic                                  v_o,
  output logic [DATA_W-1:0]                     data_o
);

  import test_dram_pkg::*;

  logic [DELAY_STAGES-1:0] v_q;
  logic [DATA_W-1:0]       data_q [DELAY_STAGES];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[DELAY_STAGES-2:0], v_i};
    end
  end

  // Data rides along with its valid bit
  always_ff @(posedge clk_i) begin
    data_q[0] <= data_i;
    for (int s = 1; s < DELAY_STAGES; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign v_o    = v_q[delay_i]; // Later stages are simply not seen
  assign data_o = data_q[delay_i];

  // A changed tap would drop or repeat responses already in the line
  a_delay_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (|v_q) |=> $stable(delay_i))
    else $error("read delay changed with reads in flight");

endmodule

`default_nettype wire

/* rtl/mem_1r1w_sync_mask_write_byte.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-masked 1R1W memory, cleared at time zero, write-first on a collision.
// Read data is registered, so data_v_o follows r_v_i by one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_sync_mask_write_byte #(
  parameter int DATA_W = 32,
  parameter int WORDS  = 1024
) (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  input  wire logic                      r_v_i,
  input  wire logic [$clog2(WORDS)-1:0]  r_addr_i,
  input  wire logic                      w_v_i,
  input  wire logic [$clog2(WORDS)-1:0]  w_addr_i,
  input  wire logic [DATA_W-1:0]         w_data_i,
  input  wire logic [DATA_W/8-1:0]       w_mask_i,
  output logic                           data_v_o,
  output logic [DATA_W-1:0]              data_o
);

  localparam int BYTES = DATA_W / 8;

  logic [DATA_W-1:0] mem_q [WORDS] = '{default: '0};
  logic [DATA_W-1:0] rd_word;
  logic              same_word;

  assign same_word = w_v_i && (w_addr_i == r_addr_i);

  // Masked bytes of a same-cycle write win over the stored word
  always_comb begin
    rd_word = mem_q[r_addr_i];
    for (int b = 0; b < BYTES; b++) begin
      if (same_word && w_mask_i[b]) begin
        rd_word[b*8 +: 8] = w_data_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < BYTES; b++) begin
      if (w_v_i && w_mask_i[b]) begin
        mem_q[w_addr_i][b*8 +: 8] <= w_data_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_v_i) data_o <= rd_word; // Holds the last read otherwise
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= r_v_i;
    end
  end

  a_r_addr_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_v_i |-> (int'(r_addr_i) < WORDS))
    else $error("read address beyond memory");

  a_w_addr_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_v_i |-> (int'(w_addr_i) < WORDS))
    else $error("write address beyond memory");

endmodule

`default_nettype wire

/* rtl/test_dram_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Test memory channel, read latency is 2 + rd_delay cycles in command order.
// No back-pressure: the client must take every rsp_v_o pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module test_dram_channel #(
  parameter int DATA_W = 32, // Multiple of 8
  parameter int ADDR_W = 12  // Byte address width
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic                                 cmd_v_i,
  input  wire logic                                 cmd_we_i,
  input  wire logic [ADDR_W-1:0]                    cmd_addr_i,
  input  wire logic [DATA_W-1:0]                    cmd_wdata_i,
  input  wire logic [DATA_W/8-1:0]                  cmd_mask_i,
  input  wire logic                                 cfg_we_i,
  input  wire logic [test_dram_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  wire logic [test_dram_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  output logic                                      rsp_v_o,
  output logic      [DATA_W-1:0]                    rsp_data_o,
  output logic      [test_dram_pkg::CFG_DATA_W-1:0] cfg_rdata_o
);

  import test_dram_pkg::*;

  localparam int BYTES   = DATA_W / 8;
  localparam int WORDS   = (1 << ADDR_W) / BYTES;
  localparam int WORD_AW = $clog2(WORDS);

  logic               enable;
  logic [DELAY_W-1:0] rd_delay;
  logic               rd_fire;
  logic               wr_fire;
  logic               err_fire;
  logic               r_v;
  logic [WORD_AW-1:0] r_addr;
  logic               w_v;
  logic [WORD_AW-1:0] w_addr;
  logic [DATA_W-1:0]  w_data;
  logic [BYTES-1:0]   w_mask;
  logic               mem_v;
  logic [DATA_W-1:0]  mem_data;

  dram_cfg_regs u_regs (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .rd_fire_i   (rd_fire),
    .wr_fire_i   (wr_fire),
    .err_fire_i  (err_fire),
    .cfg_rdata_o (cfg_rdata_o),
    .enable_o    (enable),
    .rd_delay_o  (rd_delay)
  );

  dram_cmd_decode #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_we_i    (cmd_we_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .cmd_mask_i  (cmd_mask_i),
    .enable_i    (enable),
    .r_v_o       (r_v),
    .r_addr_o    (r_addr),
    .w_v_o       (w_v),
    .w_addr_o    (w_addr),
    .w_data_o    (w_data),
    .w_mask_o    (w_mask),
    .rd_fire_o   (rd_fire),
    .wr_fire_o   (wr_fire),
    .err_fire_o  (err_fire)
  );

  mem_1r1w_sync_mask_write_byte #(
    .DATA_W (DATA_W),
    .WORDS  (WORDS)
  ) u_mem (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .r_v_i    (r_v),
    .r_addr_i (r_addr),
    .w_v_i    (w_v),
    .w_addr_i (w_addr),
    .w_data_i (w_data),
    .w_mask_i (w_mask),
    .data_v_o (mem_v),
    .data_o   (mem_data)
  );

  dram_read_delay #(
    .DATA_W (DATA_W)
  ) u_delay (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (mem_v),
    .data_i   (mem_data),
    .delay_i  (rd_delay),
    .v_o      (rsp_v_o),
    .data_o   (rsp_data_o)
  );

endmodule

`default_nettype wire

/* rtl/test_dram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants of the test memory channel and its register map.
// The read delay field is DELAY_W bits, so the delay line has 2**DELAY_W taps.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package test_dram_pkg;

  // Register port widths
  localparam int CFG_ADDR_W = 2;
  localparam int CFG_DATA_W = 32;

  // Extra read delay, 0 to 7 cycles
  localparam int DELAY_W      = 3;
  localparam int DELAY_STAGES = 1 << DELAY_W; // Shift line depth

  // CTRL register layout
  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_DLY_LSB = 1;

  // Register map, writes to the counters are ignored
  typedef enum logic [CFG_ADDR_W-1:0] {
    CFG_CTRL    = 2'd0,
    CFG_RD_CNT  = 2'd1,
    CFG_WR_CNT  = 2'd2,
    CFG_ERR_CNT = 2'd3
  } cfg_reg_e;

endpackage

`default_nettype wire

/* verif/tb_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running testbench clock and an active-low reset.
// Reset is released on a falling edge after RST_CYCLES rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1; // Away from the rising edge
  end

endmodule

`default_nettype wire

/* verif/tb_test_dram_channel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench of the test memory channel with a reference memory.
// Read delay changes only after the response queue drains and the line empties.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_test_dram_channel;

  import test_dram_pkg::*;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;
  localparam int BYTES  = DATA_W / 8;
  localparam int WORDS  = (1 << ADDR_W) / BYTES;

  typedef enum int {OP_IDLE, OP_WR, OP_RD, OP_CFG_WR, OP_CFG_RD} op_e;

  logic                  clk;
  logic                  arst_n;
  logic                  cmd_v;
  logic                  cmd_we;
  logic [ADDR_W-1:0]     cmd_addr;
  logic [DATA_W-1:0]     cmd_wdata;
  logic [BYTES-1:0]      cmd_mask;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  rsp_v;
  logic [DATA_W-1:0]     rsp_data;
  logic [CFG_DATA_W-1:0] cfg_rdata;

  // Step table with one entry per index
  string             st_name [$];
  op_e               st_op   [$];
  logic [ADDR_W-1:0] st_addr [$];
  logic [DATA_W-1:0] st_data [$];
  logic [BYTES-1:0]  st_mask [$];
  bit                st_rsp  [$];

  // Reference model of memory and registers
  logic [DATA_W-1:0]     ref_mem [WORDS] = '{default: '0};
  logic [CFG_DATA_W-1:0] ctrl_m;
  logic [CFG_DATA_W-1:0] rd_m;
  logic [CFG_DATA_W-1:0] wr_m;
  logic [CFG_DATA_W-1:0] err_m;
  int                    dly_m;

  // Outstanding reads in command order
  logic [DATA_W-1:0] exp_data_q [$];
  int                exp_cyc_q  [$];
  int                exp_dly_q  [$];
  string             exp_name_q [$];

  int cyc = 0;
  int watchdog_cycles = 0;

  tb_clk_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (2)
  ) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  test_dram_channel #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) u_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .cmd_v_i     (cmd_v),
    .cmd_we_i    (cmd_we),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .cmd_mask_i  (cmd_mask),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .rsp_v_o     (rsp_v),
    .rsp_data_o  (rsp_data),
    .cfg_rdata_o (cfg_rdata)
  );

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) report_error($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_cfg(input string name, input logic [CFG_DATA_W-1:0] exp,
                           input logic [CFG_DATA_W-1:0] act);
    if (act !== exp) report_error($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) report_error($sformatf("error: %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic add_step(input string name, input op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [BYTES-1:0] mask,
                          input bit rsp);
    st_name.push_back(name);
    st_op.push_back(op);
    st_addr.push_back(addr);
    st_data.push_back(data);
    st_mask.push_back(mask);
    st_rsp.push_back(rsp);
  endtask

  task automatic build_table();
    add_step("rst_ctrl", OP_CFG_RD, 12'h0, '0, '0, 1'b0);
    add_step("rst_rd_cnt", OP_CFG_RD, 12'h1, '0, '0, 1'b0);
    add_step("rst_wr_cnt", OP_CFG_RD, 12'h2, '0, '0, 1'b0);
    add_step("rst_err_cnt", OP_CFG_RD, 12'h3, '0, '0, 1'b0);
    add_step("enable", OP_CFG_WR, 12'h0, 32'h1, '0, 1'b0);
    add_step("ctrl_en", OP_CFG_RD, 12'h0, '0, '0, 1'b0);
    add_step("cnt_wr_ignored", OP_CFG_WR, 12'h1, 32'h55, '0, 1'b0);
    add_step("rd_cnt_kept", OP_CFG_RD, 12'h1, '0, '0, 1'b0);
    add_step("rd_unwritten_lo", OP_RD, 12'h000, '0, '0, 1'b1);
    add_step("rd_unwritten_hi", OP_RD, 12'hffc, '0, '0, 1'b1);
    add_step("wr_full", OP_WR, 12'h010, 32'h11223344, 4'hf, 1'b0);
    add_step("wr_part", OP_WR, 12'h010, 32'haabbccdd, 4'h5, 1'b0);
    add_step("rd_after_wr", OP_RD, 12'h010, '0, '0, 1'b1); // Directly follows the write
    add_step("wr_lo", OP_WR, 12'h020, 32'h01020304, 4'h3, 1'b0);
    add_step("wr_hi", OP_WR, 12'h024, 32'h05060708, 4'hc, 1'b0);
    add_step("wr_b2", OP_WR, 12'h020, 32'h00990000, 4'h4, 1'b0);
    add_step("rd_lo", OP_RD, 12'h020, '0, '0, 1'b1);
    add_step("rd_hi", OP_RD, 12'h024, '0, '0, 1'b1);
    add_step("gap", OP_IDLE, 12'h0, '0, '0, 1'b0);
    for (int k = 0; k < 8; k++) add_step("rand_wr", OP_WR, 12'h100 + 12'(4 * k), '0, '0, 1'b0);
    for (int k = 0; k < 8; k++) add_step("b2b_d0", OP_RD, 12'h100 + 12'(4 * k), '0, '0, 1'b1);
    add_step("delay5", OP_CFG_WR, 12'h0, 32'hfffffffb, '0, 1'b0); // Upper bits not stored
    add_step("ctrl_d5", OP_CFG_RD, 12'h0, '0, '0, 1'b0);
    for (int k = 0; k < 8; k++) add_step("b2b_d5", OP_RD, 12'h100 + 12'(4 * k), '0, '0, 1'b1);
    add_step("misal_wr", OP_WR, 12'h011, 32'hdeadbeef, 4'hf, 1'b0);
    add_step("misal_rd", OP_RD, 12'h022, '0, '0, 1'b0);
    add_step("rd_unchanged", OP_RD, 12'h010, '0, '0, 1'b1);
    add_step("err_cnt", OP_CFG_RD, 12'h3, '0, '0, 1'b0);
    add_step("disable", OP_CFG_WR, 12'h0, 32'ha, '0, 1'b0);
    add_step("dis_wr", OP_WR, 12'h010, 32'hffffffff, 4'hf, 1'b0);
    add_step("dis_rd", OP_RD, 12'h010, '0, '0, 1'b0);
    add_step("dis_misal", OP_RD, 12'h013, '0, '0, 1'b0);
    add_step("dis_rd_cnt", OP_CFG_RD, 12'h1, '0, '0, 1'b0);
    add_step("dis_err_cnt", OP_CFG_RD, 12'h3, '0, '0, 1'b0);
    add_step("reenable", OP_CFG_WR, 12'h0, 32'h1, '0, 1'b0);
    add_step("rd_reenabled", OP_RD, 12'h010, '0, '0, 1'b1);
    add_step("final_rd_cnt", OP_CFG_RD, 12'h1, '0, '0, 1'b0);
    add_step("final_wr_cnt", OP_CFG_RD, 12'h2, '0, '0, 1'b0);
    add_step("final_err_cnt", OP_CFG_RD, 12'h3, '0, '0, 1'b0);
    // Random payload for the random write block
    foreach (st_name[i]) begin
      if (st_name[i] == "rand_wr") begin
        st_data[i] = DATA_W'($urandom);
        st_mask[i] = BYTES'($urandom);
      end
    end
  endtask

  task automatic drive(input logic v, input logic we, input logic [ADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] data, input logic [BYTES-1:0] mask,
                       input logic c_we, input logic [CFG_ADDR_W-1:0] c_addr);
    @(posedge clk);
    cmd_v     <= v;
    cmd_we    <= we;
    cmd_addr  <= addr;
    cmd_wdata <= data;
    cmd_mask  <= mask;
    cfg_we    <= c_we;
    cfg_addr  <= c_addr;
    cfg_wdata <= data;
  endtask

  // Drain responses, then let valids leave all eight delay stages
  task automatic quiesce();
    drive(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    while (exp_data_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
  endtask

  task automatic apply_step(input int i);
    logic [CFG_ADDR_W-1:0] reg_a;
    logic [CFG_DATA_W-1:0] exp_cfg;
    int                    word;
    bit                    aligned;
    bit                    en;
    reg_a   = st_addr[i][CFG_ADDR_W-1:0];
    word    = int'(st_addr[i]) / BYTES;
    aligned = (int'(st_addr[i]) % BYTES) == 0;
    en      = ctrl_m[CTRL_EN_BIT];
    exp_cfg = '0;
    case (st_op[i])
      OP_WR, OP_RD: begin
        drive(1'b1, st_op[i] == OP_WR, st_addr[i], st_data[i], st_mask[i], 1'b0, reg_a);
        if (en && !aligned) begin
          err_m = err_m + 1'b1;
        end else if (en && st_op[i] == OP_WR) begin
          wr_m = wr_m + 1'b1;
          for (int b = 0; b < BYTES; b++) begin
            if (st_mask[i][b]) ref_mem[word][b*8 +: 8] = st_data[i][b*8 +: 8];
          end
        end else if (en) begin
          rd_m = rd_m + 1'b1;
        end
        if (st_rsp[i]) begin
          exp_data_q.push_back(ref_mem[word]);
          exp_cyc_q.push_back(cyc + 2); // Edge at which the DUT samples it
          exp_dly_q.push_back(dly_m);
          exp_name_q.push_back(st_name[i]);
        end
      end
      OP_CFG_WR: begin
        if (cfg_reg_e'(reg_a) == CFG_CTRL) quiesce();
        drive(1'b0, 1'b0, '0, st_data[i], '0, 1'b1, reg_a);
        if (cfg_reg_e'(reg_a) == CFG_CTRL) begin
          ctrl_m = '0;
          ctrl_m[CTRL_EN_BIT] = st_data[i][CTRL_EN_BIT];
          ctrl_m[CTRL_DLY_LSB +: DELAY_W] = st_data[i][CTRL_DLY_LSB +: DELAY_W];
          dly_m = int'(st_data[i][CTRL_DLY_LSB +: DELAY_W]);
        end
      end
      OP_CFG_RD: begin
        drive(1'b0, 1'b0, '0, '0, '0, 1'b0, reg_a);
        @(posedge clk); // Counters settle one edge after the fire pulse
        @(negedge clk);
        case (cfg_reg_e'(reg_a))
          CFG_CTRL:    exp_cfg = ctrl_m;
          CFG_RD_CNT:  exp_cfg = rd_m;
          CFG_WR_CNT:  exp_cfg = wr_m;
          CFG_ERR_CNT: exp_cfg = err_m;
          default:     exp_cfg = '0;
        endcase
        check_cfg(st_name[i], exp_cfg, cfg_rdata);
      end
      default: drive(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    endcase
  endtask

  // Response monitor sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && rsp_v) begin
      if (exp_data_q.size() == 0) begin
        report_error("read response returned with no read outstanding");
      end else begin
        check_data(exp_name_q[0], exp_data_q[0], rsp_data);
        check_latency(exp_name_q[0], 2 + exp_dly_q[0], cyc - exp_cyc_q[0]);
        void'(exp_data_q.pop_front());
        void'(exp_cyc_q.pop_front());
        void'(exp_dly_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    report_error($sformatf("watchdog expired after %0d cycles with %0d reads outstanding",
                           watchdog_cycles, exp_data_q.size()));
  end

  initial begin
    void'($urandom(3));
    cmd_v     = 1'b0;
    cmd_we    = 1'b0;
    cmd_addr  = '0;
    cmd_wdata = '0;
    cmd_mask  = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    ctrl_m    = '0;
    rd_m      = '0;
    wr_m      = '0;
    err_m     = '0;
    dly_m     = 0;
    build_table();
    watchdog_cycles = (st_name.size() + 20) * 10;
    wait (arst_n);
    for (int i = 0; i < st_name.size(); i++) apply_step(i);
    quiesce(); // Also catches any stray late response
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
